// File: common/mem_msg_pkg.sv
// Message formats for the word-wide processor port and the line-wide memory port
// All addresses are byte addresses; line requests use line-aligned addresses
`default_nettype none

package mem_msg_pkg;

  // Request and response kind, shared by both ports
  typedef enum logic [1:0] {
    READ  = 2'd0,
    WRITE = 2'd1,
    INIT  = 2'd2   // Write a word without refill, processor port only
  } mem_type_e;

  // Processor request, 66 bits
  typedef struct packed {
    mem_type_e   msg_type;
    logic [31:0] addr;
    logic [31:0] data;
  } word_req_t;

  // Processor response, 35 bits
  typedef struct packed {
    mem_type_e   msg_type;
    logic        hit;
    logic [31:0] data;   // Zero for write and init
  } word_resp_t;

  // Memory request, 162 bits
  typedef struct packed {
    mem_type_e    msg_type;  // READ or WRITE
    logic [31:0]  addr;
    logic [127:0] data;
  } line_req_t;

  // Memory response, 130 bits
  typedef struct packed {
    mem_type_e    msg_type;
    logic [127:0] data;
  } line_resp_t;

endpackage

`default_nettype wire

// File: common/cache_pkg.sv
// Geometry and control types of the direct-mapped cache
// Line geometry is fixed; the number of sets is a module parameter
`default_nettype none

package cache_pkg;

  localparam int LINE_WORDS  = 4;               // Words per line
  localparam int OFFSET_BITS = 4;               // Byte offset within a line
  localparam int LINE_BITS   = 32 * LINE_WORDS;

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    INIT_ACCESS,
    READ_ACCESS,
    WRITE_ACCESS,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE,
    EVICT_PREP,
    EVICT_REQ,     // Send the dirty line, then wait for its ack
    RESP
  } ctrl_state_e;

  // Controller to datapath enables
  typedef struct packed {
    logic req_en;        // Capture the processor request
    logic tag_wen;
    logic data_wen;
    logic word_write;    // Line write merges the request word, else the refill line
    logic valid_wen;     // Set valid and write dirty_in
    logic dirty_in;
    logic read_en;       // Response data is the selected word, else zero
    logic evict_en;      // Latch victim address and line
    logic memreq_evict;  // Memory request is the eviction write
    logic hit_en;
    logic resp_type_en;  // Load response type and data
    logic memresp_en;
  } ctrl_t;

  // Datapath to controller status
  typedef struct packed {
    mem_msg_pkg::mem_type_e req_type;
    logic                   hit;
    logic                   victim_dirty;
  } status_t;

endpackage

`default_nettype wire

// File: cache/cache_ctrl.sv
// Blocking cache controller, one request in flight
// The eviction write ack is awaited in EVICT_REQ before the refill starts
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl
  import mem_msg_pkg::*, cache_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  logic    cachereq_val,
  output logic    cachereq_rdy,
  output logic    cacheresp_val,
  input  logic    cacheresp_rdy,

  output logic    memreq_val,
  input  logic    memreq_rdy,
  input  logic    memresp_val,
  output logic    memresp_rdy,

  output ctrl_t   ctrl,
  input  status_t status
);

  ctrl_state_e state;
  ctrl_state_e next_state;
  logic        evict_sent;   // Eviction write accepted, waiting for the ack
  logic        evict_sent_next;

  //--------------------------------------------------------------------
  // State register
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      evict_sent <= 1'b0;
    end else begin
      state      <= next_state;
      evict_sent <= evict_sent_next;
    end
  end

  // Stays set from the write transfer until the ack arrives
  assign evict_sent_next = (state == EVICT_REQ) && (evict_sent || memreq_rdy)
                           && !(evict_sent && memresp_val);

  //--------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (cachereq_val) next_state = TAG_CHECK;
      end
      TAG_CHECK: begin
        if (status.req_type == INIT) begin
          next_state = INIT_ACCESS;            // Init never refills
        end else if (status.hit) begin
          if (status.req_type == WRITE) next_state = WRITE_ACCESS;
          else                          next_state = READ_ACCESS;
        end else if (status.victim_dirty) begin
          next_state = EVICT_PREP;
        end else begin
          next_state = REFILL_REQ;
        end
      end
      INIT_ACCESS,
      READ_ACCESS,
      WRITE_ACCESS: next_state = RESP;
      REFILL_REQ: begin
        if (memreq_rdy) next_state = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        if (memresp_val) next_state = REFILL_UPDATE;
      end
      REFILL_UPDATE: begin
        if (status.req_type == WRITE) next_state = WRITE_ACCESS;
        else                          next_state = READ_ACCESS;
      end
      EVICT_PREP: next_state = EVICT_REQ;
      EVICT_REQ: begin
        if (evict_sent && memresp_val) next_state = REFILL_REQ;
      end
      RESP: begin
        if (cacheresp_rdy) next_state = IDLE;
      end
      default: next_state = IDLE;
    endcase
  end

  //--------------------------------------------------------------------
  // State outputs
  //--------------------------------------------------------------------

  always_comb begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    ctrl          = '0;
    case (state)
      IDLE: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = 1'b1;
      end
      TAG_CHECK: ctrl.hit_en = 1'b1;
      INIT_ACCESS: begin
        ctrl.tag_wen      = 1'b1;
        ctrl.data_wen     = 1'b1;
        ctrl.word_write   = 1'b1;
        ctrl.valid_wen    = 1'b1;   // Valid and clean
        ctrl.resp_type_en = 1'b1;
      end
      READ_ACCESS: begin
        ctrl.read_en      = 1'b1;
        ctrl.resp_type_en = 1'b1;
      end
      WRITE_ACCESS: begin
        ctrl.data_wen     = 1'b1;
        ctrl.word_write   = 1'b1;
        ctrl.valid_wen    = 1'b1;
        ctrl.dirty_in     = 1'b1;   // Always dirty after a write
        ctrl.resp_type_en = 1'b1;
      end
      REFILL_REQ: memreq_val = 1'b1;
      REFILL_WAIT: begin
        memresp_rdy     = 1'b1;
        ctrl.memresp_en = memresp_val;
      end
      REFILL_UPDATE: begin
        ctrl.tag_wen   = 1'b1;
        ctrl.data_wen  = 1'b1;
        ctrl.valid_wen = 1'b1;      // Fresh line is clean
      end
      EVICT_PREP: ctrl.evict_en = 1'b1;
      EVICT_REQ: begin
        memreq_val        = !evict_sent;
        memresp_rdy       = evict_sent;
        ctrl.memreq_evict = 1'b1;
      end
      RESP: cacheresp_val = 1'b1;
      default: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: cache/cache_dpath.sv
// Direct-mapped cache datapath with tag, valid, dirty and data arrays
// num_sets must be a power of two of at least 2
`timescale 1ns/10ps
`default_nettype none

module cache_dpath
  import mem_msg_pkg::*, cache_pkg::*;
#(
  parameter int num_sets = 8
) (
  input  logic       clk,
  input  logic       reset,
  input  word_req_t  cachereq,
  output word_resp_t cacheresp,
  output line_req_t  memreq,
  input  line_resp_t memresp,
  input  ctrl_t      ctrl,
  output status_t    status
);

  localparam int INDEX_BITS = $clog2(num_sets);
  localparam int WOFF_BITS  = $clog2(LINE_WORDS);
  localparam int TAG_BITS   = 32 - OFFSET_BITS - INDEX_BITS;

  //--------------------------------------------------------------------
  // Request register and address split
  //--------------------------------------------------------------------

  word_req_t             req_q;
  logic [TAG_BITS-1:0]   req_tag;
  logic [INDEX_BITS-1:0] req_idx;
  logic [WOFF_BITS-1:0]  req_woff;

  always_ff @(posedge clk) begin
    if (ctrl.req_en) req_q <= cachereq;
  end

  assign req_tag  = req_q.addr[31 -: TAG_BITS];
  assign req_idx  = req_q.addr[OFFSET_BITS +: INDEX_BITS];
  assign req_woff = req_q.addr[OFFSET_BITS-WOFF_BITS +: WOFF_BITS];

  //--------------------------------------------------------------------
  // Tag array and valid/dirty record
  //--------------------------------------------------------------------

  logic [TAG_BITS-1:0] tag_array [num_sets];
  logic [num_sets-1:0] valid_bits;
  logic [num_sets-1:0] dirty_bits;

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) tag_array[req_idx] <= req_tag;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (ctrl.valid_wen) begin
      valid_bits[req_idx] <= 1'b1;
      dirty_bits[req_idx] <= ctrl.dirty_in;
    end
  end

  assign status.req_type     = req_q.msg_type;
  assign status.hit          = valid_bits[req_idx] && (tag_array[req_idx] == req_tag);
  assign status.victim_dirty = valid_bits[req_idx] && dirty_bits[req_idx];

  //--------------------------------------------------------------------
  // Data array, refill line and word merge
  //--------------------------------------------------------------------

  logic [LINE_BITS-1:0] data_array [num_sets];
  logic [LINE_BITS-1:0] refill_line;
  logic [LINE_BITS-1:0] line_in;

  always_ff @(posedge clk) begin
    if (ctrl.memresp_en) refill_line <= memresp.data;
  end

  always_comb begin
    if (ctrl.word_write) begin
      line_in = data_array[req_idx];
      line_in[req_woff*32 +: 32] = req_q.data;   // Replace one word in place
    end else begin
      line_in = refill_line;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) data_array[req_idx] <= line_in;
  end

  //--------------------------------------------------------------------
  // Eviction and memory request
  //--------------------------------------------------------------------

  logic [31:0]          evict_addr;
  logic [LINE_BITS-1:0] evict_line;

  always_ff @(posedge clk) begin
    if (ctrl.evict_en) begin
      evict_addr <= {tag_array[req_idx], req_idx, {OFFSET_BITS{1'b0}}};
      evict_line <= data_array[req_idx];
    end
  end

  assign memreq.msg_type = ctrl.memreq_evict ? WRITE : READ;
  assign memreq.addr     = ctrl.memreq_evict ? evict_addr
                                             : {req_tag, req_idx, {OFFSET_BITS{1'b0}}};
  assign memreq.data     = ctrl.memreq_evict ? evict_line : '0;

  //--------------------------------------------------------------------
  // Response registers
  //--------------------------------------------------------------------

  logic        hit_q;
  mem_type_e   resp_type_q;
  logic [31:0] read_data_q;

  always_ff @(posedge clk) begin
    if (ctrl.hit_en) hit_q <= status.hit && (req_q.msg_type != INIT);   // Init is a miss
  end

  always_ff @(posedge clk) begin
    if (ctrl.resp_type_en) begin
      resp_type_q <= req_q.msg_type;
      read_data_q <= ctrl.read_en ? data_array[req_idx][req_woff*32 +: 32] : '0;
    end
  end

  assign cacheresp.msg_type = resp_type_q;
  assign cacheresp.hit      = hit_q;
  assign cacheresp.data     = read_data_q;

endmodule

`default_nettype wire

// File: cache/cache_top.sv
// Blocking write-back, write-allocate cache, direct mapped with 16-byte lines
// Init writes a word and marks its line valid and clean with no refill
`timescale 1ns/10ps
`default_nettype none

module cache_top
  import mem_msg_pkg::*, cache_pkg::*;
#(
  parameter int num_sets = 8   // Power of two, at least 2
) (
  input  logic       clk,
  input  logic       reset,

  // Processor port
  input  logic       cachereq_val,
  output logic       cachereq_rdy,
  input  word_req_t  cachereq,
  output logic       cacheresp_val,
  input  logic       cacheresp_rdy,
  output word_resp_t cacheresp,

  // Memory port
  output logic       memreq_val,
  input  logic       memreq_rdy,
  output line_req_t  memreq,
  input  logic       memresp_val,
  output logic       memresp_rdy,
  input  line_resp_t memresp
);

  ctrl_t   ctrl;
  status_t status;

  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .ctrl          (ctrl),
    .status        (status)
  );

  cache_dpath #(
    .num_sets (num_sets)
  ) u_dpath (
    .clk       (clk),
    .reset     (reset),
    .cachereq  (cachereq),
    .cacheresp (cacheresp),
    .memreq    (memreq),
    .memresp   (memresp),
    .ctrl      (ctrl),
    .status    (status)
  );

endmodule

`default_nettype wire

// File: dv/test_mem.sv
// Line-wide memory model of 256 words, addresses wrap at 1 KB
// Each word starts as its byte address with the upper half inverted
`timescale 1ns/10ps
`default_nettype none

module test_mem
  import mem_msg_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       memreq_val,
  output logic       memreq_rdy,
  input  line_req_t  memreq,
  output logic       memresp_val,
  input  logic       memresp_rdy,
  output line_resp_t memresp
);

  logic [31:0] mem [256];
  logic        busy;            // Request taken, response not yet delivered
  logic [1:0]  delay;
  logic [7:0]  base;
  logic [31:0] rnd;
  integer      seed;

  initial begin : fill
    logic [31:0] a;
    seed        = 32'h2258b81a;
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp     = '0;
    for (int i = 0; i < 256; i++) begin
      a = 32'(i) << 2;
      mem[i] = {~a[31:16], a[15:0]};
    end
  end

  always @(posedge clk) begin
    rnd = $random(seed);
    if (reset) begin
      memreq_rdy  <= 1'b0;
      memresp_val <= 1'b0;
      busy        <= 1'b0;
      delay       <= 2'd0;
    end else if (!busy) begin
      if (memreq_val && memreq_rdy) begin
        base = {memreq.addr[9:4], 2'b00};
        if (memreq.msg_type == WRITE) begin
          mem[base]        <= memreq.data[31:0];
          mem[base + 8'd1] <= memreq.data[63:32];
          mem[base + 8'd2] <= memreq.data[95:64];
          mem[base + 8'd3] <= memreq.data[127:96];
          memresp.data     <= '0;   // Write ack carries no data
        end else begin
          memresp.data <= {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
        end
        memresp.msg_type <= memreq.msg_type;
        delay            <= rnd[1:0];
        busy             <= 1'b1;
        memreq_rdy       <= 1'b0;
      end else begin
        memreq_rdy <= (rnd[3:2] != 2'd0);   // Back-pressure about a quarter of the time
      end
    end else if (!memresp_val) begin
      if (delay == 2'd0) memresp_val <= 1'b1;
      else               delay <= delay - 2'd1;
    end else if (memresp_rdy) begin
      memresp_val <= 1'b0;
      busy        <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: dv/cache_tb.sv
// Cache testbench with directed cases and a random mix over 64 words
// Random inits always cover a whole line so no word is left undefined
`timescale 1ns/10ps
`default_nettype none

module cache_tb
  import mem_msg_pkg::*;
;

  localparam int num_sets   = 8;
  localparam int total_reqs = 1300;   // Upper bound, random inits expand to 4 requests

  logic       clk;
  logic       reset;
  logic       cachereq_val;
  logic       cachereq_rdy;
  word_req_t  cachereq;
  logic       cacheresp_val;
  logic       cacheresp_rdy;
  word_resp_t cacheresp;
  logic       memreq_val;
  logic       memreq_rdy;
  line_req_t  memreq;
  logic       memresp_val;
  logic       memresp_rdy;
  line_resp_t memresp;

  integer      seed;
  int          errors;
  int          compared;
  int          rdy_mode;      // 0 high, 1 random, 2 low for the first 8 cycles
  word_resp_t  exp_q[$];
  line_req_t   mreq_log[$];
  logic [31:0] ref_mem [256];
  int          sh_tag [num_sets];
  logic        sh_valid [num_sets];
  logic        sh_dirty [num_sets];
  logic [31:0] sh_line [num_sets][4];

  cache_top #(.num_sets(num_sets)) dut (.*);

  test_mem u_mem (
    .clk(clk), .reset(reset),
    .memreq_val(memreq_val), .memreq_rdy(memreq_rdy), .memreq(memreq),
    .memresp_val(memresp_val), .memresp_rdy(memresp_rdy), .memresp(memresp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return {~a[31:16], a[15:0]};
  endfunction

  //----------------------------------------------------------------------
  // Reference model: flat memory plus a shadow of each set
  //----------------------------------------------------------------------

  function automatic word_resp_t ref_access(input word_req_t r);
    int         idx;
    int         tag;
    int         w;
    word_resp_t e;
    idx = int'(r.addr[6:4]);
    tag = int'(r.addr >> 7);
    w   = int'(r.addr[3:2]);
    e.msg_type = r.msg_type;
    e.hit      = 1'b0;
    e.data     = '0;
    if (r.msg_type == INIT) begin   // No refill, no eviction, always a miss
      sh_tag[idx]      = tag;
      sh_valid[idx]    = 1'b1;
      sh_dirty[idx]    = 1'b0;
      sh_line[idx][w]  = r.data;
      return e;
    end
    e.hit = sh_valid[idx] && (sh_tag[idx] == tag);
    if (!e.hit) begin
      if (sh_valid[idx] && sh_dirty[idx]) begin
        for (int k = 0; k < 4; k++) begin
          ref_mem[((sh_tag[idx] << 5) | (idx << 2) | k) & 255] = sh_line[idx][k];
        end
      end
      for (int k = 0; k < 4; k++) begin
        sh_line[idx][k] = ref_mem[((tag << 5) | (idx << 2) | k) & 255];
      end
      sh_tag[idx]   = tag;
      sh_valid[idx] = 1'b1;
      sh_dirty[idx] = 1'b0;
    end
    if (r.msg_type == WRITE) begin
      sh_line[idx][w] = r.data;
      sh_dirty[idx]   = 1'b1;
    end else begin
      e.data = sh_line[idx][w];
    end
    return e;
  endfunction

  // Issue one request, wait for its response transfer, return the latency
  task automatic send_req(input mem_type_e t, input logic [31:0] a, input logic [31:0] d,
                          output int lat);
    word_req_t   r;
    logic        done;
    logic [31:0] rnd;
    r.msg_type = t;
    r.addr     = a;
    r.data     = d;
    exp_q.push_back(ref_access(r));
    cachereq_val <= 1'b1;
    cachereq     <= r;
    @(posedge clk);
    while (!cachereq_rdy) @(posedge clk);
    cachereq_val <= 1'b0;
    lat  = 0;
    done = 1'b0;
    while (!done) begin
      rnd = $random(seed);
      if (rdy_mode == 1)      cacheresp_rdy <= rnd[0];
      else if (rdy_mode == 2) cacheresp_rdy <= (lat >= 8);
      else                    cacheresp_rdy <= 1'b1;
      @(posedge clk);
      lat++;
      assert (!cachereq_rdy) else begin   // Blocking cache takes no second request
        errors++;
        $display("CHECK FAILED at %0t: cachereq_rdy high with a request in flight", $time);
      end
      if (cacheresp_val && cacheresp_rdy) done = 1'b1;
    end
    cacheresp_rdy <= 1'b1;
  endtask

  //----------------------------------------------------------------------
  // Response comparison and memory request log
  //----------------------------------------------------------------------

  logic       held_v;
  word_resp_t held;

  always @(posedge clk) begin
    if (cacheresp_val && held_v) begin   // Payload must not move while stalled
      assert (cacheresp == held) else begin
        errors++;
        $display("CHECK FAILED at %0t: response changed while stalled", $time);
      end
    end
    if (cacheresp_val && cacheresp_rdy) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Response arrived with no request outstanding at %0t", $time);
      end else begin
        assert (cacheresp == exp_q[0]) else begin
          errors++;
          $display("CHECK FAILED at %0t: got type %0d hit %0b data %h, expected %0d %0b %h",
                   $time, cacheresp.msg_type, cacheresp.hit, cacheresp.data,
                   exp_q[0].msg_type, exp_q[0].hit, exp_q[0].data);
        end
        void'(exp_q.pop_front());
        compared++;
      end
    end
    held_v = cacheresp_val && !cacheresp_rdy;
    held   = cacheresp;
    if (memreq_val && memreq_rdy) mreq_log.push_back(memreq);
  end

  // Watchdog
  initial begin
    repeat (16 + total_reqs * 40) @(posedge clk);
    $display("Timeout: the cache stopped responding");
    $display("Errors: %0d, responses compared: %0d", errors, compared);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------

  initial begin : stim
    int          lat;
    logic [31:0] rnd;
    logic [31:0] a;
    logic [127:0] line;
    seed          = 32'h2258b81a;
    errors        = 0;
    compared      = 0;
    rdy_mode      = 0;
    held_v        = 1'b0;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq      = '0;
    cacheresp_rdy = 1'b1;
    for (int i = 0; i < 256; i++) ref_mem[i] = init_word(32'(i) << 2);
    for (int s = 0; s < num_sets; s++) begin
      sh_valid[s] = 1'b0;
      sh_dirty[s] = 1'b0;
      sh_tag[s]   = 0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // Idle handshake levels out of reset
    assert (cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy) else begin
      errors++;
      $display("CHECK FAILED at %0t: handshake outputs wrong after reset", $time);
    end

    // Init a whole line, then read one word back as a hit
    for (int k = 0; k < 4; k++) begin
      send_req(INIT, 32'h200 + 32'(k * 4), 32'hA5A50000 + 32'(k), lat);
    end
    send_req(READ, 32'h204, '0, lat);

    // Cold read misses, second read of the line hits
    send_req(READ, 32'h050, '0, lat);
    send_req(READ, 32'h054, '0, lat);

    // Write hit, then neighbours keep their values
    send_req(WRITE, 32'h058, 32'h1234_5678, lat);
    send_req(READ, 32'h058, '0, lat);
    send_req(READ, 32'h054, '0, lat);

    // Dirty line evicted by a conflicting read
    send_req(WRITE, 32'h034, 32'hDEAD_BEEF, lat);
    mreq_log.delete();
    send_req(READ, 32'h0B4, '0, lat);
    line = {init_word(32'h3C), init_word(32'h38), 32'hDEAD_BEEF, init_word(32'h30)};
    assert (mreq_log.size() == 2 && mreq_log[0].msg_type == WRITE && mreq_log[0].addr == 32'h030
            && mreq_log[0].data == line && mreq_log[1].msg_type == READ
            && mreq_log[1].addr == 32'h0B0) else begin
      errors++;
      $display("CHECK FAILED at %0t: eviction sequence wrong, %0d memory requests",
               $time, mreq_log.size());
    end
    send_req(READ, 32'h034, '0, lat);

    // Hit latency, then a response held under back-pressure
    send_req(READ, 32'h050, '0, lat);
    assert (lat == 3) else begin
      errors++;
      $display("CHECK FAILED at %0t: hit latency %0d, expected 3", $time, lat);
    end
    rdy_mode = 2;
    send_req(READ, 32'h058, '0, lat);

    // Random mix over 64 words
    rdy_mode = 1;
    for (int n = 0; n < 300; n++) begin
      rnd = $random(seed);
      a   = {24'd0, rnd[5:0], 2'b00};
      if (rnd[11:8] < 4'd7) begin
        send_req(READ, a, '0, lat);
      end else if (rnd[11:8] < 4'd14) begin
        send_req(WRITE, a, $random(seed), lat);
      end else begin
        for (int k = 0; k < 4; k++) begin
          send_req(INIT, {a[31:4], 4'd0} + 32'(k * 4), $random(seed), lat);
        end
      end
    end

    repeat (4) @(posedge clk);
    $display("Errors: %0d, responses compared: %0d", errors, compared);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
common/mem_msg_pkg.sv
common/cache_pkg.sv
cache/cache_ctrl.sv
cache/cache_dpath.sv
cache/cache_top.sv
dv/test_mem.sv
dv/cache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sim.f --top-module cache_tb -o cache_tb_sim

output=$(./obj_dir/cache_tb_sim)
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
